//--- collective_router.f
verilog/collective_pkg.sv
verilog/comm_table.sv
verilog/flit_decode.sv
verilog/route_select.sv
verilog/flit_result.sv
verilog/collective_router.sv
test/flit_checker.sv
test/tb_collective_router.sv

//--- run_sim.sh
#!/bin/sh
# build and run the collective router testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 \
	--top-module tb_collective_router \
	-f collective_router.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Something failed" "$LOG"; then
	exit 1
fi
exit 0

//--- test/flit_checker.sv
`timescale 1ns/10ps

module flit_checker #(
	parameter collective_pkg::coord_t NODE_COORD = '0
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  collective_pkg::flit_t                 in_flit,
	input  logic                                  in_valid,
	input  logic                                  in_ready,
	input  collective_pkg::out_flit_t             out_flit,
	input  logic                                  out_valid,
	input  logic                                  out_ready,
	input  logic                                  cfg_we,
	input  logic [collective_pkg::COMM_IDX_W-1:0] cfg_idx,
	input  collective_pkg::comm_entry_t           cfg_entry,
	output int                                    error_count,
	output int                                    pending
);

	import collective_pkg::*;

	comm_entry_t table_copy [COMM_TABLE_SIZE];  // shadow of the DUT table
	out_flit_t   expected_q [$];                // oldest flit first

	//////////////////////////////////////////////////
	// reference model

	// home selects the second copy of a guest ring flit
	function automatic out_flit_t expected_flit(input flit_t f, input comm_entry_t e,
			input logic home);
		out_flit_t r;
		r.children = e.children;
		r.flit     = f;
		if (f.dst == f.src) begin
			r.flit.rank = e.local_rank;  // self-addressed
		end
		if (f.op == OP_GATHER || f.op == OP_SHORT_REDUCE) begin
			// tree root keeps the flit
			r.flit.dst = (e.local_rank == '0) ? NODE_COORD : e.parent;
		end else if (f.op == OP_LARGE_ALLGATHER) begin
			r.flit.dst = home ? NODE_COORD : e.ring_next;
		end
		return r;  // any other opcode keeps dst
	endfunction

	//////////////////////////////////////////////////
	// sampling, mid-cycle where every port is settled

	always @(negedge clk) begin
		out_flit_t   want;
		comm_entry_t e;
		if (rst) begin
			for (int i = 0; i < COMM_TABLE_SIZE; i++) begin
				table_copy[i] = '0;
			end
			expected_q.delete();
			error_count = 0;
		end else begin
			if (out_valid && out_ready) begin  // output taken at next edge
				if (expected_q.size() == 0) begin
					$display("%0t: output flit arrived while none was expected", $time);
					error_count++;
				end else begin
					want = expected_q.pop_front();
					if (out_flit !== want) begin
						$display("[ERROR] %0t out_flit expected %h got %h", $time, want, out_flit);
						error_count++;
					end
				end
			end
			if (in_valid && in_ready) begin
				e = table_copy[in_flit.context_id[COMM_IDX_W-1:0]];
				expected_q.push_back(expected_flit(in_flit, e, 1'b0));
				// a guest ring flit also goes home
				if (in_flit.op == OP_LARGE_ALLGATHER && in_flit.src != NODE_COORD) begin
					expected_q.push_back(expected_flit(in_flit, e, 1'b1));
				end
			end
			if (cfg_we) begin
				table_copy[cfg_idx] = cfg_entry;  // DUT writes at next edge
			end
		end
		pending = expected_q.size();
	end

endmodule

//--- test/tb_collective_router.sv
`timescale 1ns/10ps

module tb_collective_router;

	import collective_pkg::*;

	localparam coord_t NODE         = '{z: 3'd1, y: 3'd0, x: 3'd1};
	localparam coord_t GUEST        = '{z: 3'd2, y: 3'd3, x: 3'd4};
	localparam int     WAIT_LIMIT   = 1000;  // cycles per wait loop
	localparam int     RANDOM_FLITS = 300;

	logic                  clk;
	logic                  rst;
	flit_t                 in_flit;
	logic                  in_valid;
	logic                  in_ready;
	out_flit_t             out_flit;
	logic                  out_valid;
	logic                  out_ready;
	logic                  cfg_we;
	logic [COMM_IDX_W-1:0] cfg_idx;
	comm_entry_t           cfg_entry;

	logic [31:0] lfsr_state;
	logic        random_ready;  // new out_ready every cycle
	logic        stalled;       // set once a wait times out
	int          tb_errors;
	int          check_errors;
	int          pending;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns
	end

	collective_router #(.NODE_COORD(NODE)) collective_router_i (
		.clk       (clk),
		.rst       (rst),
		.in_flit   (in_flit),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_flit  (out_flit),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.cfg_we    (cfg_we),
		.cfg_idx   (cfg_idx),
		.cfg_entry (cfg_entry)
	);

	flit_checker #(.NODE_COORD(NODE)) flit_checker_i (
		.clk         (clk),
		.rst         (rst),
		.in_flit     (in_flit),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_flit    (out_flit),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.cfg_we      (cfg_we),
		.cfg_idx     (cfg_idx),
		.cfg_entry   (cfg_entry),
		.error_count (check_errors),
		.pending     (pending)
	);

	//////////////////////////////////////////////////
	// random bits

	// galois form, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);  // one step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// inputs move 1 ns after the edge
	task automatic next_cycle();
		logic [31:0] r;
		@(posedge clk);
		#1;
		if (random_ready) begin
			take_bits(1, r);
			out_ready = r[0];
		end
	endtask

	task automatic random_flit(output flit_t f);
		logic [31:0] r;
		f.valid = 1'b1;
		take_bits(2, r);
		case (r[1:0])
			2'd0:    f.op = OP_GATHER;
			2'd1:    f.op = OP_SHORT_REDUCE;
			2'd2:    f.op = OP_LARGE_ALLGATHER;
			default: begin
				take_bits(OP_W, r);
				f.op = op_e'(r[OP_W-1:0]);  // anything, mostly pass-through
			end
		endcase
		take_bits(CONTEXT_W, r);
		f.context_id = r[CONTEXT_W-1:0];
		take_bits(1, r);
		if (r[0]) begin
			f.src = NODE;  // local source
		end else begin
			take_bits(3*COORD_W, r);
			f.src = coord_t'(r[3*COORD_W-1:0]);
		end
		take_bits(2, r);
		if (r[1:0] == 2'd0) begin
			f.dst = f.src;  // self-addressed
		end else begin
			take_bits(3*COORD_W, r);
			f.dst = coord_t'(r[3*COORD_W-1:0]);
		end
		take_bits(RANK_W, r);
		f.rank = r[RANK_W-1:0];
		take_bits(TAG_W, r);
		f.tag = r[TAG_W-1:0];
		take_bits(ALGTYPE_W, r);
		f.algtype = r[ALGTYPE_W-1:0];
		take_bits(PAYLOAD_W, r);
		f.payload = r;
	endtask

	//////////////////////////////////////////////////
	// drivers and waits

	// handshake seen at the negedge, transfer on the following edge
	task automatic send_flit(input flit_t f);
		int   waited;
		logic taken;
		if (!stalled) begin
			in_flit  = f;
			in_valid = 1'b1;
			taken    = 1'b0;
			waited   = 0;
			while (!taken && waited < WAIT_LIMIT) begin
				@(negedge clk);
				taken = in_ready;
				next_cycle();
				waited++;
			end
			in_valid = 1'b0;
			if (!taken) begin
				$display("%0t: timed out, input flit was never accepted", $time);
				tb_errors++;
				stalled = 1'b1;
			end
		end
	endtask

	task automatic write_entry(input logic [COMM_IDX_W-1:0] idx, input comm_entry_t e);
		cfg_we    = 1'b1;
		cfg_idx   = idx;
		cfg_entry = e;
		next_cycle();
		cfg_we    = 1'b0;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (!stalled && pending != 0 && waited < WAIT_LIMIT) begin
			next_cycle();
			waited++;
		end
		if (pending != 0) begin
			$display("%0t: timed out, %0d expected flits never came out", $time, pending);
			tb_errors++;
			stalled = 1'b1;
		end
	endtask

	// one edge into decode, one into the result register
	task automatic check_latency();
		flit_t f;
		int    cycles;
		logic  seen;
		random_flit(f);
		f.op = OP_GATHER;
		send_flit(f);
		cycles = 0;
		seen   = 1'b0;
		while (!stalled && !seen && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
			seen = out_valid;
		end
		if (!stalled && !seen) begin
			$display("%0t: timed out, out_valid never rose", $time);
			tb_errors++;
			stalled = 1'b1;
		end else if (seen && cycles != 2) begin
			$display("[ERROR] %0t out_valid latency expected 2 got %0d", $time, cycles);
			tb_errors++;
		end
		next_cycle();
		wait_drained();
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		flit_t       f;
		comm_entry_t e;
		logic [31:0] r;
		rst          = 1'b1;
		in_flit      = '0;
		in_valid     = 1'b0;
		out_ready    = 1'b1;
		cfg_we       = 1'b0;
		cfg_idx      = '0;
		cfg_entry    = '0;
		lfsr_state   = 32'h84be;
		random_ready = 1'b0;
		stalled      = 1'b0;
		tb_errors    = 0;

		repeat (7) @(posedge clk);
		@(negedge clk);
		if (out_valid !== 1'b0) begin
			$display("[ERROR] %0t out_valid expected 0 got %b", $time, out_valid);
			tb_errors++;
		end
		@(posedge clk);  // eighth reset edge
		#1;
		rst = 1'b0;
		@(negedge clk);
		if (in_ready !== 1'b1) begin
			$display("[ERROR] %0t in_ready expected 1 got %b", $time, in_ready);
			tb_errors++;
		end
		next_cycle();

		// context 0 is a tree root, the others are not
		for (int i = 0; i < COMM_TABLE_SIZE; i++) begin
			take_bits(30, r);
			e = comm_entry_t'(r[29:0]);
			if (i == 0)
				e.local_rank = '0;
			else if (e.local_rank == '0)
				e.local_rank = 9'd1;
			write_entry(COMM_IDX_W'(i), e);
		end

		check_latency();

		// every route class on every context
		for (int c = 0; c < COMM_TABLE_SIZE; c++) begin
			for (int k = 0; k < 6; k++) begin
				random_flit(f);
				f.context_id[COMM_IDX_W-1:0] = COMM_IDX_W'(c);
				case (k)
					0: f.op = OP_GATHER;
					1: f.op = OP_SHORT_REDUCE;
					2: begin
						f.op  = OP_LARGE_ALLGATHER;
						f.src = GUEST;  // two outputs
					end
					3: begin
						f.op  = OP_LARGE_ALLGATHER;
						f.src = NODE;   // one output
					end
					4: begin
						f.op  = op_e'(4'd9);
						f.dst = f.src;
					end
					default: begin
						f.op    = OP_NONE;
						f.dst   = f.src;
						f.dst.y = ~f.src.y;  // never self-addressed
					end
				endcase
				send_flit(f);
			end
		end
		wait_drained();

		// random traffic under back-pressure
		random_ready = 1'b1;
		for (int n = 0; n < RANDOM_FLITS; n++) begin
			random_flit(f);
			send_flit(f);
			take_bits(1, r);
			if (r[0] && !stalled)
				next_cycle();  // idle gap
		end
		wait_drained();
		random_ready = 1'b0;
		out_ready    = 1'b1;

		$display("errors: %0d from the checker, %0d from the testbench", check_errors, tb_errors);
		if (check_errors == 0 && tb_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- verilog/collective_pkg.sv
package collective_pkg;

	//////////////////////////////////////////////////
	// field widths

	localparam int COORD_W    = 3;  // one mesh axis
	localparam int RANK_W     = 9;
	localparam int CONTEXT_W  = 8;
	localparam int TAG_W      = 8;
	localparam int ALGTYPE_W  = 2;
	localparam int OP_W       = 4;
	localparam int PAYLOAD_W  = 32;
	localparam int CHILDREN_W = 3;

	// communicator table, indexed by low context bits
	localparam int COMM_TABLE_SIZE = 4;
	localparam int COMM_IDX_W      = 2;

	//////////////////////////////////////////////////
	// coordinates and opcodes

	typedef struct packed {
		logic [COORD_W-1:0] z;
		logic [COORD_W-1:0] y;
		logic [COORD_W-1:0] x;
	} coord_t;  // 9 bits

	// any value not listed here passes straight through
	typedef enum logic [OP_W-1:0] {
		OP_NONE            = 4'd0,
		OP_LARGE_ALLGATHER = 4'd4,  // ring
		OP_GATHER          = 4'd6,  // up-tree
		OP_SHORT_REDUCE    = 4'd7   // up-tree
	} op_e;

	//////////////////////////////////////////////////
	// flits

	typedef struct packed {
		logic                  valid;
		coord_t                dst;
		coord_t                src;
		logic [RANK_W-1:0]     rank;
		logic [CONTEXT_W-1:0]  context_id;
		logic [TAG_W-1:0]      tag;
		logic [ALGTYPE_W-1:0]  algtype;
		op_e                   op;
		logic [PAYLOAD_W-1:0]  payload;
	} flit_t;  // 82 bits

	typedef struct packed {
		logic [CHILDREN_W-1:0] children;  // from the communicator entry
		flit_t                 flit;
	} out_flit_t;  // 85 bits

	// one communicator as seen from this node
	typedef struct packed {
		logic [RANK_W-1:0]     local_rank;
		logic [CHILDREN_W-1:0] children;
		coord_t                parent;     // up-tree target
		coord_t                ring_next;  // ring successor
	} comm_entry_t;  // 30 bits

	//////////////////////////////////////////////////
	// routing classes and ring sequencing

	typedef enum logic [1:0] {
		ROUTE_PASS,
		ROUTE_UPTREE,
		ROUTE_RING
	} route_e;

	typedef enum logic {
		RING_FORWARD,  // send on to successor
		RING_HOME      // then deliver locally
	} ring_state_e;

	// decode stage contents
	typedef struct packed {
		flit_t       flit;
		comm_entry_t entry;
		route_e      route;
		logic        from_guest;  // src is another node
	} decoded_t;

endpackage

//--- verilog/collective_router.sv
`timescale 1ns/10ps

module collective_router #(
	parameter collective_pkg::coord_t NODE_COORD = '0
) (
	input  logic                                  clk,
	input  logic                                  rst,
	// input flit port
	input  collective_pkg::flit_t                 in_flit,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	// output flit port
	output collective_pkg::out_flit_t             out_flit,
	output logic                                  out_valid,
	input  logic                                  out_ready,
	// communicator configuration
	input  logic                                  cfg_we,
	input  logic [collective_pkg::COMM_IDX_W-1:0] cfg_idx,
	input  collective_pkg::comm_entry_t           cfg_entry
);

	import collective_pkg::*;

	logic [COMM_IDX_W-1:0] table_idx;
	comm_entry_t           entry;
	decoded_t              dec;
	logic                  dec_valid, dec_ready;
	out_flit_t             routed;
	logic                  routed_valid, res_ready;

	//////////////////////////////////////////////////
	// table, decode, route, result

	comm_table comm_table_i (
		.clk       (clk),
		.rst       (rst),
		.cfg_we    (cfg_we),
		.cfg_idx   (cfg_idx),
		.cfg_entry (cfg_entry),
		.rd_idx    (table_idx),
		.rd_entry  (entry)
	);

	flit_decode #(.NODE_COORD(NODE_COORD)) flit_decode_i (
		.clk       (clk),
		.rst       (rst),
		.in_flit   (in_flit),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.table_idx (table_idx),
		.entry     (entry),
		.dec       (dec),
		.dec_valid (dec_valid),
		.dec_ready (dec_ready)
	);

	route_select #(.NODE_COORD(NODE_COORD)) route_select_i (
		.clk          (clk),
		.rst          (rst),
		.dec          (dec),
		.dec_valid    (dec_valid),
		.dec_ready    (dec_ready),
		.routed       (routed),
		.routed_valid (routed_valid),
		.res_ready    (res_ready)
	);

	flit_result flit_result_i (
		.clk          (clk),
		.rst          (rst),
		.routed       (routed),
		.routed_valid (routed_valid),
		.res_ready    (res_ready),
		.out_flit     (out_flit),
		.out_valid    (out_valid),
		.out_ready    (out_ready)
	);

endmodule

//--- verilog/comm_table.sv
`timescale 1ns/10ps

module comm_table (
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cfg_we,
	input  logic [collective_pkg::COMM_IDX_W-1:0] cfg_idx,
	input  collective_pkg::comm_entry_t         cfg_entry,
	input  logic [collective_pkg::COMM_IDX_W-1:0] rd_idx,
	output collective_pkg::comm_entry_t         rd_entry
);

	import collective_pkg::*;

	//////////////////////////////////////////////////
	// storage

	comm_entry_t comm_mem [COMM_TABLE_SIZE];  // one entry per communicator

	// cleared on reset so an unconfigured context reads as zero
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < COMM_TABLE_SIZE; i++) begin
				comm_mem[i] <= '0;
			end
		end else if (cfg_we) begin
			comm_mem[cfg_idx] <= cfg_entry;  // visible next edge
		end
	end

	//////////////////////////////////////////////////
	// lookup

	// combinational read, decode registers the result
	assign rd_entry = comm_mem[rd_idx];

endmodule

//--- verilog/flit_decode.sv
`timescale 1ns/10ps

module flit_decode #(
	parameter collective_pkg::coord_t NODE_COORD = '0
) (
	input  logic                                  clk,
	input  logic                                  rst,
	input  collective_pkg::flit_t                 in_flit,
	input  logic                                  in_valid,
	output logic                                  in_ready,
	output logic [collective_pkg::COMM_IDX_W-1:0] table_idx,
	input  collective_pkg::comm_entry_t           entry,
	output collective_pkg::decoded_t              dec,
	output logic                                  dec_valid,
	input  logic                                  dec_ready
);

	import collective_pkg::*;

	decoded_t dec_next;
	logic     accept;

	// table indexed straight off the incoming context
	assign table_idx = in_flit.context_id[COMM_IDX_W-1:0];

	// stage empty, or its contents leave this cycle
	assign in_ready = !dec_valid || dec_ready;
	assign accept   = in_valid && in_ready;

	//////////////////////////////////////////////////
	// classify and rewrite

	always_comb begin
		dec_next            = '0;
		dec_next.flit       = in_flit;
		dec_next.entry      = entry;
		dec_next.from_guest = (in_flit.src != NODE_COORD);

		case (in_flit.op)
			OP_GATHER,
			OP_SHORT_REDUCE:    dec_next.route = ROUTE_UPTREE;
			OP_LARGE_ALLGATHER: dec_next.route = ROUTE_RING;
			default:            dec_next.route = ROUTE_PASS;  // everything else
		endcase

		// self-addressed flit takes the local rank
		if (in_flit.dst == in_flit.src) begin
			dec_next.flit.rank = entry.local_rank;
		end
	end

	//////////////////////////////////////////////////
	// stage register

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else if (accept) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;  // drained, nothing new
		end
	end

	// payload only, follows dec_valid
	always_ff @(posedge clk) begin
		if (accept) begin
			dec <= dec_next;
		end
	end

endmodule

//--- verilog/flit_result.sv
`timescale 1ns/10ps

module flit_result (
	input  logic                      clk,
	input  logic                      rst,
	input  collective_pkg::out_flit_t routed,
	input  logic                      routed_valid,
	output logic                      res_ready,
	output collective_pkg::out_flit_t out_flit,
	output logic                      out_valid,
	input  logic                      out_ready
);

	import collective_pkg::*;

	out_flit_t out_q;
	logic      load;

	// take a new flit if empty or draining this cycle
	assign res_ready = !out_valid || out_ready;
	assign load      = routed_valid && res_ready;

	//////////////////////////////////////////////////
	// output register

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (res_ready) begin
			out_valid <= routed_valid;  // holds under back-pressure
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			out_q <= routed;
		end
	end

	assign out_flit = out_q;

endmodule

//--- verilog/route_select.sv
`timescale 1ns/10ps

module route_select #(
	parameter collective_pkg::coord_t NODE_COORD = '0
) (
	input  logic                      clk,
	input  logic                      rst,
	input  collective_pkg::decoded_t  dec,
	input  logic                      dec_valid,
	output logic                      dec_ready,
	output collective_pkg::out_flit_t routed,
	output logic                      routed_valid,
	input  logic                      res_ready
);

	import collective_pkg::*;

	ring_state_e ring_state;
	logic        guest_ring;  // ring flit that needs two outputs
	logic        ring_hold;   // keep decode stage for the home copy
	coord_t      new_dst;

	assign guest_ring = dec_valid && (dec.route == ROUTE_RING) && dec.from_guest;
	assign ring_hold  = guest_ring && (ring_state == RING_FORWARD);

	//////////////////////////////////////////////////
	// destination by route class

	always_comb begin
		case (dec.route)
			ROUTE_UPTREE: begin
				// root of the tree keeps it
				if (dec.entry.local_rank == '0)
					new_dst = NODE_COORD;
				else
					new_dst = dec.entry.parent;
			end
			ROUTE_RING: begin
				if (ring_state == RING_HOME)
					new_dst = NODE_COORD;  // second copy
				else
					new_dst = dec.entry.ring_next;
			end
			default: new_dst = dec.flit.dst;  // pass-through
		endcase
	end

	always_comb begin
		routed          = '0;
		routed.flit     = dec.flit;
		routed.flit.dst = new_dst;
		routed.children = dec.entry.children;
	end

	assign routed_valid = dec_valid;
	assign dec_ready    = res_ready && !ring_hold;

	//////////////////////////////////////////////////
	// ring forward/home sequencing

	// advance only when the result stage takes the current copy
	always_ff @(posedge clk) begin
		if (rst) begin
			ring_state <= RING_FORWARD;
		end else if (guest_ring && res_ready) begin
			case (ring_state)
				RING_FORWARD: ring_state <= RING_HOME;
				RING_HOME:    ring_state <= RING_FORWARD;  // home copy gone
				default:      ring_state <= RING_FORWARD;
			endcase
		end
	end

endmodule
